// File: residuTop.f
residuPkg.sv
residuIf.sv
residuMem.sv
fracMac.sv
satAlu.sv
longShifter.sv
residuSequencer.sv
residuTop.sv
tbResidu.sv

// File: Makefile
TOP = tbResidu

.PHONY: compile run clean

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): residuTop.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f residuTop.f

# Exit status comes from the search for the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// File: tbResidu.sv
`timescale 1ns/10ps

module tbResidu import residuPkg::*; ();

	localparam int ORDER = 10;
	localparam int NUM_CASES = 7;

	// lg, coefficient base, sample base, output base, patterns, second start
	typedef struct packed {
		logic [5:0] lg;
		addrT aBase;
		addrT xBase;
		addrT yBase;
		logic [1:0] coefSel;
		logic [1:0] sampSel;
		logic extraStart;
	} caseT;

	// Patterns 0 impulse or small ramp, 1 random, 2 all MIN_SHORT, 3 large gain
	localparam caseT CASES [NUM_CASES] = '{
		'{6'd8,  11'h010, 11'h100, 11'h400, 2'd0, 2'd0, 1'b0},
		'{6'd12, 11'h020, 11'h140, 11'h440, 2'd1, 2'd1, 1'b0},
		'{6'd6,  11'h030, 11'h180, 11'h480, 2'd2, 2'd2, 1'b0},
		'{6'd8,  11'h040, 11'h1c0, 11'h4c0, 2'd3, 2'd3, 1'b0},
		'{6'd0,  11'h050, 11'h200, 11'h500, 2'd1, 2'd1, 1'b0},
		'{6'd10, 11'h060, 11'h240, 11'h540, 2'd1, 2'd1, 1'b0},
		'{6'd10, 11'h070, 11'h280, 11'h580, 2'd1, 2'd0, 1'b1}
	};

	logic clk;
	logic reset;
	logic start;
	logic [5:0] lg;
	addrT aBase;
	addrT xBase;
	addrT yBase;
	logic loadEn;
	addrT loadAddr;
	longT loadData;
	addrT hostAddr;
	logic done;
	longT hostData;

	// Expected memory contents
	longT model [MEM_WORDS];
	int errors = 0;
	int checks = 0;
	int casesFailed = 0;
	int doneCount = 0;
	int cycles = 0;
	int limit = 0;

	residuTop #(
		.ORDER (ORDER)
	) u_residuTop (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.lg       (lg),
		.aBase    (aBase),
		.xBase    (xBase),
		.yBase    (yBase),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.hostAddr (hostAddr),
		.done     (done),
		.hostData (hostData)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (done)
			doneCount <= doneCount + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("Timeout: run still going after %0d cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////
	// Reference model
	////////////////////

	function automatic longT satLong(input longint v);
		if (v > longint'(MAX_LONG))
			return MAX_LONG;
		if (v < longint'(MIN_LONG))
			return MIN_LONG;
		return longT'(v);
	endfunction

	function automatic longT fracMul(input shortT a, input shortT b);
		return satLong(2 * longint'(a) * longint'(b));
	endfunction

	// Scale, round, keep the high half sign extended
	function automatic longT outputWord(input longT acc);
		longT scaled;
		longT rounded;
		scaled = satLong(longint'(acc) <<< SHIFT_AMOUNT);
		rounded = satLong(longint'(scaled) + longint'(ROUND_CONST));
		return rounded >>> 16;
	endfunction

	function automatic shortT coefValue(input logic [1:0] sel, input int j);
		case (sel)
			2'd0: return (j == 0) ? 16'sh4000 : 16'sh0;
			2'd1: return shortT'($urandom) >>> 2;
			2'd2: return MIN_SHORT;
			default: return (j == 0) ? MAX_SHORT : 16'sh0;
		endcase
	endfunction

	function automatic shortT sampValue(input logic [1:0] sel, input int k);
		shortT mag;
		mag = shortT'(k * 113);
		case (sel)
			2'd0: return k[0] ? -mag : mag;
			2'd1: return shortT'($urandom);
			2'd2: return MIN_SHORT;
			default: return k[0] ? -(16'sh6000 + mag) : 16'sh6000 + mag;
		endcase
	endfunction

	task automatic computeExpected(input int c);
		caseT tc;
		longT acc;
		shortT coef;
		shortT samp;
		tc = CASES[c];
		for (int i = 0; i < int'(tc.lg); i++)
		begin
			acc = '0;
			for (int j = 0; j <= ORDER; j++)
			begin
				coef = model[tc.aBase + addrT'(j)][15:0];
				samp = model[addrT'(int'(tc.xBase) + i - j)][15:0];
				acc = satLong(longint'(acc) + longint'(fracMul(coef, samp)));
			end
			model[tc.yBase + addrT'(i)] = outputWord(acc);
		end
	endtask

	////////////////////
	// Host port tasks
	////////////////////

	task automatic loadWord(input addrT addr, input longT data);
		@(posedge clk);
		loadEn <= 1'b1;
		loadAddr <= addr;
		loadData <= data;
		model[addr] = data;
	endtask

	// Coefficients, history plus new samples, and a sentinel past the outputs
	task automatic preload(input int c);
		caseT tc;
		tc = CASES[c];
		for (int j = 0; j <= ORDER; j++)
			loadWord(tc.aBase + addrT'(j), {16'ha5a5, coefValue(tc.coefSel, j)});
		for (int k = 0; k < ORDER + int'(tc.lg); k++)
			loadWord(tc.xBase - addrT'(ORDER) + addrT'(k),
				{16'h5a5a, sampValue(tc.sampSel, k)});
		loadWord(tc.yBase + addrT'(tc.lg), {16'hdead, 5'd0, tc.yBase + addrT'(tc.lg)});
		@(posedge clk);
		loadEn <= 1'b0;
	endtask

	task automatic checkWord(input int c, input addrT addr, input int idx);
		longT got;
		@(posedge clk);
		hostAddr <= addr;
		@(posedge clk);
		@(negedge clk);
		got = hostData;
		checks++;
		assert (got === model[addr])
		else
		begin
			$display("MISMATCH at %0t: case %0d index %0d read %h expected %h",
				$time, c, idx, got, model[addr]);
			errors++;
		end
	endtask

	// Each sample costs 3*ORDER+9 cycles, start and finish add a few more
	task automatic runCase(input int c);
		caseT tc;
		int startCycle;
		int maxLatency;
		tc = CASES[c];
		maxLatency = int'(tc.lg) * (3 * ORDER + 9) + 4;
		@(posedge clk);
		lg <= tc.lg;
		aBase <= tc.aBase;
		xBase <= tc.xBase;
		yBase <= tc.yBase;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		startCycle = cycles;
		// Second pulse lands while the sequencer is busy
		if (tc.extraStart)
		begin
			repeat (6) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		do
			@(negedge clk);
		while (!done);
		// A restart on the second pulse would push done late
		assert (cycles - startCycle <= maxLatency)
		else
		begin
			$display("Case %0d: done came %0d cycles after start, at most %0d allowed",
				c, cycles - startCycle, maxLatency);
			errors++;
		end
		repeat (4) @(posedge clk);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		int failedBefore;
		void'($urandom(32'h7b8fc97d));
		reset <= 1'b1;
		start <= 1'b0;
		lg <= '0;
		aBase <= '0;
		xBase <= '0;
		yBase <= '0;
		loadEn <= 1'b0;
		loadAddr <= '0;
		loadData <= '0;
		hostAddr <= '0;
		limit = 20;
		for (int c = 0; c < NUM_CASES; c++)
			limit += int'(CASES[c].lg) * (3 * ORDER + 9) + 8 * int'(CASES[c].lg)
				+ 2 * ORDER + 60;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		for (int c = 0; c < NUM_CASES; c++)
		begin
			failedBefore = errors;
			preload(c);
			computeExpected(c);
			runCase(c);
			assert (doneCount == c + 1)
			else
			begin
				$display("Case %0d: done seen %0d times in total, expected %0d",
					c, doneCount, c + 1);
				errors++;
			end
			// Outputs plus the sentinel one word past them
			for (int i = 0; i <= int'(CASES[c].lg); i++)
				checkWord(c, CASES[c].yBase + addrT'(i), i);
			if (errors == failedBefore)
				$display("Case %0d lg %0d: pass", c, CASES[c].lg);
			else
			begin
				casesFailed++;
				$display("Case %0d lg %0d: fail, %0d errors", c, CASES[c].lg,
					errors - failedBefore);
			end
		end

		// Later runs must not disturb earlier outputs
		failedBefore = errors;
		for (int c = 0; c < NUM_CASES; c++)
			for (int i = 0; i <= int'(CASES[c].lg); i++)
				checkWord(c, CASES[c].yBase + addrT'(i), i);
		$display("Readback of all outputs: %s", (errors == failedBefore) ? "pass" : "fail");

		$display("Summary: %0d cases, %0d failed, %0d checks, %0d errors",
			NUM_CASES, casesFailed, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: residuTop.sv
`timescale 1ns/10ps

module residuTop import residuPkg::*; #(
	parameter int ORDER = 10
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  logic [5:0] lg,
	input  addrT       aBase,
	input  addrT       xBase,
	input  addrT       yBase,
	input  logic       loadEn,
	input  addrT       loadAddr,
	input  longT       loadData,
	input  addrT       hostAddr,
	output logic       done,
	output longT       hostData
);

	logic busy;

	memPort memBus();
	macPort macBus();
	aluPort aluBus();
	shiftPort shiftBus();

	////////////////////
	// Control
	////////////////////

	residuSequencer #(
		.ORDER (ORDER)
	) u_residuSequencer (
		.clk   (clk),
		.reset (reset),
		.start (start),
		.lg    (lg),
		.aBase (aBase),
		.xBase (xBase),
		.yBase (yBase),
		.done  (done),
		.busy  (busy),
		.mem   (memBus.ctrl),
		.mac   (macBus.ctrl),
		.alu   (aluBus.ctrl),
		.shift (shiftBus.ctrl)
	);

	////////////////////
	// Memory and arithmetic units
	////////////////////

	residuMem u_residuMem (
		.clk      (clk),
		.reset    (reset),
		.busy     (busy),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.hostAddr (hostAddr),
		.hostData (hostData),
		.mem      (memBus.unit)
	);

	fracMac u_fracMac (
		.mac (macBus.unit)
	);

	satAlu u_satAlu (
		.alu (aluBus.unit)
	);

	longShifter u_longShifter (
		.clk   (clk),
		.reset (reset),
		.shift (shiftBus.unit)
	);

endmodule

// File: residuSequencer.sv
`timescale 1ns/10ps

module residuSequencer import residuPkg::*; #(
	parameter int ORDER = 10
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  logic [5:0] lg,
	input  addrT       aBase,
	input  addrT       xBase,
	input  addrT       yBase,
	output logic       done,
	output logic       busy,
	memPort.ctrl       mem,
	macPort.ctrl       mac,
	aluPort.ctrl       alu,
	shiftPort.ctrl     shift
);

	localparam logic [3:0] INIT = 4'd0;
	localparam logic [3:0] FOR1 = 4'd1;
	localparam logic [3:0] MEM1 = 4'd2;
	localparam logic [3:0] LMULT = 4'd3;
	localparam logic [3:0] FOR2 = 4'd4;
	localparam logic [3:0] MEM2 = 4'd5;
	localparam logic [3:0] LMAC = 4'd6;
	localparam logic [3:0] LSHL = 4'd7;
	localparam logic [3:0] ROUND = 4'd8;
	localparam logic [3:0] FINISH = 4'd9;

	logic [3:0] state, nextState;
	logic [5:0] i, nextI;
	// Five bits so the tap count can pass ORDER of 15
	logic [4:0] j, nextJ;
	shortT temp, nextTemp;
	longT acc, nextAcc;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= INIT;
			i <= '0;
			j <= 5'd1;
		end
		else
		begin
			state <= nextState;
			i <= nextI;
			j <= nextJ;
		end
	end

	always_ff @(posedge clk)
	begin
		temp <= nextTemp;
		acc <= nextAcc;
	end

	assign busy = (state != INIT);

	////////////////////
	// Loop control
	////////////////////

	always_comb
	begin
		nextState = state;
		nextI = i;
		nextJ = j;
		nextTemp = temp;
		nextAcc = acc;
		done = 1'b0;
		mem.readAddr1 = '0;
		mem.readAddr2 = '0;
		mem.writeEn = 1'b0;
		mem.writeAddr = '0;
		mem.writeData = '0;
		mac.opA = '0;
		mac.opB = '0;
		mac.accIn = '0;
		alu.addA = '0;
		alu.addB = '0;
		alu.subA = '0;
		alu.subB = '0;
		alu.longA = '0;
		alu.longB = '0;
		shift.operand = acc;
		shift.amount = SHIFT_AMOUNT;
		shift.ready = 1'b0;

		case (state)
			INIT:
			begin
				nextI = '0;
				nextJ = 5'd1;
				if (start)
					nextState = FOR1;
			end

			// Fetch x[i] or finish
			FOR1:
			begin
				if (i < lg)
				begin
					alu.addA = {5'd0, xBase};
					alu.addB = {10'd0, i};
					mem.readAddr2 = alu.addSum[10:0];
					nextState = MEM1;
				end
				else
					nextState = FINISH;
			end

			MEM1:
			begin
				mem.readAddr1 = aBase;
				nextTemp = mem.dataIn2.halves.lo;
				nextState = LMULT;
			end

			LMULT:
			begin
				mac.opA = temp;
				mac.opB = mem.dataIn1.halves.lo;
				nextAcc = mac.multResult;
				nextState = FOR2;
			end

			// Coefficient table sits on a 16-word boundary
			FOR2:
			begin
				if (j <= ORDER)
				begin
					mem.readAddr1 = {aBase[10:4], j[3:0]};
					nextState = MEM2;
				end
				else
				begin
					// Exit cycle already raises ready with the final sum
					shift.ready = 1'b1;
					nextState = LSHL;
				end
			end

			// x[i-j], may reach back into the history before xBase
			MEM2:
			begin
				alu.subA = {10'd0, i};
				alu.subB = {11'd0, j};
				alu.addA = {5'd0, xBase};
				alu.addB = alu.subDiff;
				mem.readAddr2 = alu.addSum[10:0];
				nextTemp = mem.dataIn1.halves.lo;
				nextState = LMAC;
			end

			LMAC:
			begin
				mac.opA = temp;
				mac.opB = mem.dataIn2.halves.lo;
				mac.accIn = acc;
				nextAcc = mac.macResult;
				alu.addA = {11'd0, j};
				alu.addB = 16'sd1;
				nextJ = alu.addSum[4:0];
				nextState = FOR2;
			end

			LSHL:
			begin
				shift.ready = !shift.done;
				if (shift.done)
				begin
					nextAcc = shift.result;
					nextState = ROUND;
				end
			end

			// Round, keep the high half, sign extended
			ROUND:
			begin
				alu.longA = acc;
				alu.longB = ROUND_CONST;
				mem.writeData.longWord = {{16{alu.longSum[31]}}, alu.longSum[31:16]};
				alu.addA = {5'd0, yBase};
				alu.addB = {10'd0, i};
				mem.writeAddr = alu.addSum[10:0];
				mem.writeEn = 1'b1;
				nextI = i + 6'd1;
				nextJ = 5'd1;
				nextState = FOR1;
			end

			FINISH:
			begin
				done = 1'b1;
				nextState = INIT;
			end

			default:
				nextState = INIT;
		endcase
	end

endmodule

// File: longShifter.sv
`timescale 1ns/10ps

module longShifter import residuPkg::*; (
	input  logic clk,
	input  logic reset,
	shiftPort.unit shift
);

	logic active;
	logic [15:0] count;
	logic doneReg;
	longT value;

	logic load;

	// Accept a new operand only between jobs
	assign load = !active && shift.ready;

	////////////////////
	// Count and handshake
	////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active <= 1'b0;
			count <= '0;
			doneReg <= 1'b0;
		end
		else
		begin
			doneReg <= 1'b0;
			if (load)
			begin
				count <= shift.amount;
				active <= (shift.amount != 16'd0);
				doneReg <= (shift.amount == 16'd0);
			end
			else if (active)
			begin
				count <= count - 16'd1;
				if (count == 16'd1)
				begin
					active <= 1'b0;
					doneReg <= 1'b1;
				end
			end
		end
	end

	// One bit per cycle, sign bit never changes so it picks the clip value
	always_ff @(posedge clk)
	begin
		if (load)
			value <= shift.operand;
		else if (active)
		begin
			if (value[31] != value[30])
				value <= value[31] ? MIN_LONG : MAX_LONG;
			else
				value <= value <<< 1;
		end
	end

	assign shift.result = value;
	assign shift.done = doneReg;

endmodule

// File: satAlu.sv
`timescale 1ns/10ps

module satAlu import residuPkg::*; (
	aluPort.unit alu
);

	shortT rawSum;
	shortT rawDiff;
	longT rawLong;

	// 16-bit add, overflow when both signs agree and the result flips
	always_comb
	begin
		rawSum = alu.addA + alu.addB;
		if (alu.addA[15] == alu.addB[15] && rawSum[15] != alu.addA[15])
		begin
			if (alu.addA[15])
				alu.addSum = MIN_SHORT;
			else
				alu.addSum = MAX_SHORT;
		end
		else
		begin
			alu.addSum = rawSum;
		end
	end

	// 16-bit subtract, overflow only when the signs differ
	always_comb
	begin
		rawDiff = alu.subA - alu.subB;
		if (alu.subA[15] != alu.subB[15] && rawDiff[15] != alu.subA[15])
		begin
			if (alu.subA[15])
				alu.subDiff = MIN_SHORT;
			else
				alu.subDiff = MAX_SHORT;
		end
		else
		begin
			alu.subDiff = rawDiff;
		end
	end

	// 32-bit add used for rounding
	always_comb
	begin
		rawLong = alu.longA + alu.longB;
		if (alu.longA[31] == alu.longB[31] && rawLong[31] != alu.longA[31])
			alu.longSum = alu.longA[31] ? MIN_LONG : MAX_LONG;
		else
			alu.longSum = rawLong;
	end

endmodule

// File: fracMac.sv
`timescale 1ns/10ps

module fracMac import residuPkg::*; (
	macPort.unit mac
);

	longT product;
	longT fracProd;
	logic signed [32:0] wideSum;

	////////////////////
	// Fractional multiply
	////////////////////

	always_comb
	begin
		product = mac.opA * mac.opB;
		// Only -1 times -1 overflows the doubled product
		if (mac.opA == MIN_SHORT && mac.opB == MIN_SHORT)
			fracProd = MAX_LONG;
		else
			fracProd = product <<< 1;
	end

	assign mac.multResult = fracProd;

	////////////////////
	// Accumulate with saturation
	////////////////////

	always_comb
	begin
		wideSum = {mac.accIn[31], mac.accIn} + {fracProd[31], fracProd};
		if (wideSum[32] != wideSum[31])
		begin
			// Clip by the true sign of the 33-bit sum
			if (wideSum[32])
				mac.macResult = MIN_LONG;
			else
				mac.macResult = MAX_LONG;
		end
		else
		begin
			mac.macResult = wideSum[31:0];
		end
	end

endmodule

// File: residuMem.sv
`timescale 1ns/10ps

module residuMem import residuPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic busy,
	input  logic loadEn,
	input  addrT loadAddr,
	input  longT loadData,
	input  addrT hostAddr,
	output longT hostData,
	memPort.unit mem
);

	longT ram [MEM_WORDS];

	logic wrEn;
	addrT wrAddr;
	longT wrData;

	// Single write port, host loads only while the sequencer is idle
	always_comb
	begin
		wrEn = 1'b0;
		wrAddr = mem.writeAddr;
		wrData = mem.writeData.longWord;
		if (mem.writeEn)
			wrEn = 1'b1;
		else if (loadEn && !busy && !reset)
		begin
			wrEn = 1'b1;
			wrAddr = loadAddr;
			wrData = loadData;
		end
	end

	////////////////////
	// Array and registered reads
	////////////////////

	always_ff @(posedge clk)
	begin
		if (wrEn)
			ram[wrAddr] <= wrData;
		mem.dataIn1.longWord <= ram[mem.readAddr1];
		mem.dataIn2.longWord <= ram[mem.readAddr2];
		// Host read port is free at any time
		hostData <= ram[hostAddr];
	end

endmodule

// File: residuIf.sv
`timescale 1ns/10ps

// Scratch memory port, data returns one cycle after the address
interface memPort import residuPkg::*; ();
	addrT readAddr1;
	addrT readAddr2;
	logic writeEn;
	addrT writeAddr;
	memWordU writeData;
	memWordU dataIn1;
	memWordU dataIn2;

	modport ctrl (output readAddr1, readAddr2, writeEn, writeAddr, writeData,
		input dataIn1, dataIn2);
	modport unit (input readAddr1, readAddr2, writeEn, writeAddr, writeData,
		output dataIn1, dataIn2);
endinterface

// Fractional multiplier, results in the same cycle
interface macPort import residuPkg::*; ();
	shortT opA;
	shortT opB;
	longT accIn;
	longT multResult;
	longT macResult;

	modport ctrl (output opA, opB, accIn, input multResult, macResult);
	modport unit (input opA, opB, accIn, output multResult, macResult);
endinterface

// Saturating adders
interface aluPort import residuPkg::*; ();
	shortT addA, addB, addSum;
	shortT subA, subB, subDiff;
	longT longA, longB, longSum;

	modport ctrl (output addA, addB, subA, subB, longA, longB,
		input addSum, subDiff, longSum);
	modport unit (input addA, addB, subA, subB, longA, longB,
		output addSum, subDiff, longSum);
endinterface

// Multi-cycle shifter, ready held until the done pulse
interface shiftPort import residuPkg::*; ();
	longT operand;
	shortT amount;
	logic ready;
	longT result;
	logic done;

	modport ctrl (output operand, amount, ready, input result, done);
	modport unit (input operand, amount, ready, output result, done);
endinterface

// File: residuPkg.sv
package residuPkg;

	////////////////////
	// Word types
	////////////////////

	// Scratch memory address
	typedef logic [10:0] addrT;

	// Q15 fractional value
	typedef logic signed [15:0] shortT;

	// Q31 accumulator value
	typedef logic signed [31:0] longT;

	// One memory word, seen whole or as two halves
	typedef union packed {
		longT longWord;
		struct packed {
			shortT hi;
			shortT lo;
		} halves;
	} memWordU;

	////////////////////
	// Constants
	////////////////////

	localparam int MEM_WORDS = 2048;

	// Scale shift applied to every accumulated output
	localparam shortT SHIFT_AMOUNT = 16'sd3;
	localparam longT ROUND_CONST = 32'sh0000_8000;

	localparam longT MAX_LONG = 32'sh7fff_ffff;
	localparam longT MIN_LONG = 32'sh8000_0000;
	localparam shortT MAX_SHORT = 16'sh7fff;
	localparam shortT MIN_SHORT = 16'sh8000;

endpackage
